// ==== dv/tb_clock_gen.sv ====
/*
 * Testbench clock and reset
 *   100 ns clock, nRST held low for 16 cycles
 */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  initial begin
    nRST = 1'b0;
    repeat (16) @(posedge CLK);
    #1 nRST = 1'b1;
  end

endmodule

// ==== dv/vdec_stimulus.txt ====
# I op vm imm5 rs1_off vl vstart v0 (hex)
# U vs2_off0 vs2_off1 vd_off0 vd_off1 wen0 wen1 last (hex)
I 0 1 00 00 05 00 00000000
U 00 01 00 01 1 1 0
U 02 03 02 03 1 1 0
U 04 05 04 05 1 0 1
I 0 0 00 00 04 00 00000005
U 00 01 00 01 1 0 0
U 02 03 02 03 1 0 1
I 0 0 00 00 08 03 000000b6
U 03 04 03 04 0 1 0
U 05 06 05 06 1 0 0
U 07 08 07 08 1 0 1
I 1 1 00 fe 04 00 00000000
U 00 01 fe ff 1 1 0
U 02 03 00 01 1 1 1
I 2 1 05 00 02 00 00000000
U 00 01 05 06 1 1 1
I 3 1 00 10 04 00 00000000
U 10 11 00 01 1 1 0
U 12 13 02 03 1 1 1
I 4 1 1f 00 02 00 00000000
U 1f 20 00 01 1 1 1
I 5 1 00 00 02 00 00000000
U ff 00 00 01 1 1 1
I 6 1 00 00 02 00 00000000
U 01 02 00 01 1 1 1
I 7 1 00 2a 02 00 00000000
U 2a 2a 00 01 1 1 1
I 8 1 07 00 02 00 00000000
U 07 07 00 01 1 1 1
I 9 1 03 05 08 00 00000000
U 00 00 00 00 1 0 1
I 0 1 00 00 04 06 00000000
U 06 07 06 07 0 0 1
I 0 0 00 00 20 00 a5a5a5a5
U 00 01 00 01 1 0 0
U 02 03 02 03 1 0 0
U 04 05 04 05 0 1 0
U 06 07 06 07 0 1 0
U 08 09 08 09 1 0 0
U 0a 0b 0a 0b 1 0 0
U 0c 0d 0c 0d 0 1 0
U 0e 0f 0e 0f 0 1 0
U 10 11 10 11 1 0 0
U 12 13 12 13 1 0 0
U 14 15 14 15 0 1 0
U 16 17 16 17 0 1 0
U 18 19 18 19 1 0 0
U 1a 1b 1a 1b 1 0 0
U 1c 1d 1c 1d 0 1 0
U 1e 1f 1e 1f 0 1 1
I 6 1 00 00 03 01 00000000
U 02 03 01 02 1 1 1

// ==== dv/vdec_tb.sv ====
/*
 * Vector decode stage testbench
 *   instruction driver on the four-phase input handshake
 *   execute-side responder with random ack delay
 *   micro-op field checks against the stimulus file
 */
`timescale 1ns/1ps

module vdec_tb;
  import vdec_pkg::*;

  localparam int MAX_INSTR = 32;
  localparam int MAX_UOP   = 64;
  // ascii codes of the line tags
  localparam int CH_HASH   = 35;
  localparam int CH_NL     = 10;
  localparam int CH_I      = 73;
  localparam int CH_U      = 85;

  logic      CLK;
  logic      nRST;
  logic      instr_req;
  logic      instr_ack;
  vop_e      op;
  logic      vm;
  imm5_t     imm5;
  elem_off_t rs1_off;
  elem_cnt_t vl;
  elem_cnt_t vstart;
  mask_t     v0;
  logic      uop_req;
  logic      uop_ack;
  elem_off_t vs2_off0, vs2_off1, vd_off0, vd_off1;
  logic      wen0, wen1, uop_last;

  logic [31:0] ins_f [MAX_INSTR][7];
  logic [31:0] exp_f [MAX_UOP][7];
  int          n_instr;
  int          n_expected;
  int          n_received;
  int          file_lines;
  int          cycle_count;
  int          cycle_limit;

  tb_clock_gen tb_clock_gen_i (
    .CLK  (CLK),
    .nRST (nRST)
  );

  vector_decode_stage vector_decode_stage_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .instr_req (instr_req),
    .instr_ack (instr_ack),
    .op        (op),
    .vm        (vm),
    .imm5      (imm5),
    .rs1_off   (rs1_off),
    .vl        (vl),
    .vstart    (vstart),
    .v0        (v0),
    .uop_req   (uop_req),
    .uop_ack   (uop_ack),
    .vs2_off0  (vs2_off0),
    .vs2_off1  (vs2_off1),
    .vd_off0   (vd_off0),
    .vd_off1   (vd_off1),
    .wen0      (wen0),
    .wen1      (wen1),
    .uop_last  (uop_last)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0d ns: %s got %0h expected %0h (micro-op %0d)",
                          $time, name, got, exp, n_received));
    end
  endtask

  // "#" lines are comments, "I" and "U" lines carry seven hex fields
  task automatic load_stimulus();
    int          fd;
    int          c;
    int          n;
    int          k;
    logic [31:0] v [7];
    fd = $fopen("dv/vdec_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open dv/vdec_stimulus.txt");
    end else begin
      c = $fgetc(fd);
      while (c != -1) begin
        if (c == CH_HASH) begin
          while (c != -1 && c != CH_NL) c = $fgetc(fd);
        end else if (c == CH_I || c == CH_U) begin
          n = $fscanf(fd, "%h %h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
          if (n != 7 || n_instr >= MAX_INSTR || n_expected >= MAX_UOP) begin
            abort_run("stimulus file has a malformed line or too many entries");
          end else if (c == CH_I) begin
            for (k = 0; k < 7; k++) ins_f[n_instr][k] = v[k];
            n_instr++;
            file_lines++;
          end else begin
            for (k = 0; k < 7; k++) exp_f[n_expected][k] = v[k];
            n_expected++;
            file_lines++;
          end
        end
        c = $fgetc(fd);
      end
      $fclose(fd);
    end
  endtask

  // called 1 ns after a rising edge, returns at the same point
  task automatic send_instr(input int i);
    op        = vop_e'(ins_f[i][0][3:0]);
    vm        = ins_f[i][1][0];
    imm5      = ins_f[i][2][4:0];
    rs1_off   = ins_f[i][3][7:0];
    vl        = ins_f[i][4][5:0];
    vstart    = ins_f[i][5][5:0];
    v0        = ins_f[i][6];
    instr_req = 1'b1;
    do @(negedge CLK); while (instr_ack !== 1'b1);
    @(posedge CLK);
    #1 instr_req = 1'b0;
    do @(negedge CLK); while (instr_ack !== 1'b0);
    @(posedge CLK);
    #1;
  endtask

  task automatic check_uop(input int i);
    compare_value("vs2_off0", 32'(vs2_off0), exp_f[i][0]);
    compare_value("vs2_off1", 32'(vs2_off1), exp_f[i][1]);
    compare_value("vd_off0", 32'(vd_off0), exp_f[i][2]);
    compare_value("vd_off1", 32'(vd_off1), exp_f[i][3]);
    compare_value("wen0", 32'(wen0), exp_f[i][4]);
    compare_value("wen1", 32'(wen1), exp_f[i][5]);
    compare_value("uop_last", 32'(uop_last), exp_f[i][6]);
  endtask

  initial begin : driver
    int i;
    instr_req   = 1'b0;
    op          = VOP_ARITH;
    vm          = 1'b0;
    imm5        = '0;
    rs1_off     = '0;
    vl          = '0;
    vstart      = '0;
    v0          = '0;
    n_instr     = 0;
    n_expected  = 0;
    n_received  = 0;
    file_lines  = 0;
    cycle_count = 0;
    cycle_limit = 200;
    load_stimulus();
    cycle_limit = 20 * file_lines + 200;
    wait (nRST === 1'b1);
    @(posedge CLK);
    #1;
    for (i = 0; i < n_instr; i++) send_instr(i);
    while (n_received < n_expected) @(negedge CLK);
    // leave room for a stray extra micro-op
    repeat (20) @(negedge CLK);
    if (!uop_req && !instr_ack) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      abort_run("stage not idle at end of run");
    end
  end

  // execute side
  initial begin : responder
    int delay;
    void'($urandom(32'hb47f));
    uop_ack = 1'b0;
    forever begin
      do @(negedge CLK); while (uop_req !== 1'b1);
      if (n_received >= n_expected) begin
        abort_run("extra micro-op received after the last expected one");
      end else begin
        check_uop(n_received);
        n_received++;
        delay = $urandom % 4;
        repeat (delay) @(negedge CLK);
        @(posedge CLK);
        #1 uop_ack = 1'b1;
        do @(negedge CLK); while (uop_req !== 1'b0);
        @(posedge CLK);
        #1 uop_ack = 1'b0;
      end
    end
  end

  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      abort_run($sformatf("timeout after %0d cycles with %0d of %0d micro-ops received",
                          cycle_count, n_received, n_expected));
    end
  end

endmodule

// ==== hw/element_sequencer.sv ====
/*
 * Element sequencer
 *   four-phase instruction intake and field capture
 *   two-lane element walk from vstart to the effective vl
 *   vs2/vd offsets, masked write enables and last flag per micro-op
 */
`timescale 1ns/1ps

module element_sequencer (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                instr_req,
  output logic                instr_ack,
  input  vdec_pkg::vop_e      op,
  input  logic                vm,
  input  vdec_pkg::imm5_t     imm5,
  input  vdec_pkg::elem_off_t rs1_off,
  input  vdec_pkg::elem_cnt_t vl,
  input  vdec_pkg::elem_cnt_t vstart,
  input  vdec_pkg::mask_t     v0,
  input  logic                full,
  output logic                push,
  output vdec_pkg::uop_word_t push_word
);
  import vdec_pkg::*;

  seq_state_e state;
  elem_off_t  idx;
  logic       capture;

  // captured instruction
  vop_e      op_q;
  logic      vm_q;
  imm5_t     imm5_q;
  elem_off_t rs1_q;
  elem_cnt_t vl_q;
  elem_cnt_t vstart_q;
  mask_t     v0_q;

  vs2_src_e  vs2_src;
  vd_src_e   vd_src;
  logic      single_elem;
  elem_cnt_t eff_vl;
  elem_off_t uimm_off;
  elem_off_t lo_bound;
  elem_off_t hi_bound;
  elem_off_t lane1_idx;
  elem_off_t vs2_off0, vs2_off1, vd_off0, vd_off1;
  logic      wen0, wen1, last;

  function automatic elem_off_t vs2_offset(vs2_src_e src, elem_off_t lane_idx,
                                           elem_off_t rs1, elem_off_t uimm);
    case (src)
      VS2_IDX_PLUS_RS1:  return lane_idx + rs1;
      VS2_IDX_PLUS_UIMM: return lane_idx + uimm;
      VS2_IDX_PLUS_1:    return lane_idx + elem_off_t'(1);
      VS2_IDX_MINUS_1:   return lane_idx - elem_off_t'(1);
      VS2_RS1:           return rs1;
      VS2_UIMM:          return uimm;
      VS2_ZERO:          return '0;
      default:           return lane_idx;
    endcase
  endfunction

  function automatic elem_off_t vd_offset(vd_src_e src, elem_off_t lane_idx,
                                          elem_off_t rs1, elem_off_t uimm);
    case (src)
      VD_ZERO:          return '0;
      VD_IDX_PLUS_RS1:  return lane_idx + rs1;
      VD_IDX_PLUS_UIMM: return lane_idx + uimm;
      default:          return lane_idx;
    endcase
  endfunction

  // in [lo, hi) and either unmasked or v0 bit set
  function automatic logic lane_wen(elem_off_t lane_idx, elem_off_t lo, elem_off_t hi,
                                    logic unmasked, mask_t mask);
    mask_t shifted;
    shifted = mask >> lane_idx;
    return (lane_idx >= lo) && (lane_idx < hi) && (unmasked || shifted[0]);
  endfunction

  vop_decoder vop_decoder_i (
    .op          (op_q),
    .vs2_src     (vs2_src),
    .vd_src      (vd_src),
    .single_elem (single_elem)
  );

  assign eff_vl    = single_elem ? elem_cnt_t'(1) : vl_q;
  assign uimm_off  = elem_off_t'(imm5_q);
  assign lo_bound  = elem_off_t'(vstart_q);
  assign hi_bound  = elem_off_t'(eff_vl);
  assign lane1_idx = idx + elem_off_t'(1);

  assign vs2_off0 = vs2_offset(vs2_src, idx, rs1_q, uimm_off);
  assign vs2_off1 = vs2_offset(vs2_src, lane1_idx, rs1_q, uimm_off);
  assign vd_off0  = vd_offset(vd_src, idx, rs1_q, uimm_off);
  assign vd_off1  = vd_offset(vd_src, lane1_idx, rs1_q, uimm_off);
  assign wen0     = lane_wen(idx, lo_bound, hi_bound, vm_q, v0_q);
  assign wen1     = lane_wen(lane1_idx, lo_bound, hi_bound, vm_q, v0_q);
  // also true on the first step when vstart is already past vl
  assign last     = (idx + elem_off_t'(2)) >= hi_bound;

  assign capture   = (state == IDLE) && instr_req;
  assign push      = (state == ISSUE) && !full;
  assign push_word = {vs2_off0, vs2_off1, vd_off0, vd_off1, wen0, wen1, last};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state     <= IDLE;
      instr_ack <= 1'b0;
      idx       <= '0;
    end else begin
      if (instr_ack && !instr_req) begin
        instr_ack <= 1'b0;
      end
      case (state)
        IDLE: begin
          if (instr_req) begin
            instr_ack <= 1'b1;
            idx       <= elem_off_t'(vstart);
            state     <= ISSUE;
          end
        end
        ISSUE: begin
          if (push) begin
            if (last) begin
              state <= WAIT_REQ_LOW;
            end else begin
              idx <= idx + elem_off_t'(2);
            end
          end
        end
        WAIT_REQ_LOW: begin
          // wait out the ack falling edge
          if (!instr_ack) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (capture) begin
      op_q     <= op;
      vm_q     <= vm;
      imm5_q   <= imm5;
      rs1_q    <= rs1_off;
      vl_q     <= vl;
      vstart_q <= vstart;
      v0_q     <= v0;
    end
  end

endmodule

// ==== hw/uop_queue.sv ====
/*
 * Micro-op queue
 *   circular buffer of micro-op words, power-of-two depth
 *   simultaneous push and pop, full and empty flags
 */
`timescale 1ns/1ps
`include "vdec_cfg.svh"

module uop_queue #(
  parameter int DEPTH = `VDEC_QUEUE_DEPTH
) (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                push,
  input  vdec_pkg::uop_word_t push_word,
  output logic                full,
  input  logic                pop,
  output vdec_pkg::uop_word_t head_word,
  output logic                empty
);
  import vdec_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  uop_word_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_push;
  logic             do_pop;

  assign full      = count == (PTR_W+1)'(DEPTH);
  assign empty     = count == '0;
  assign do_push   = push && !full;
  assign do_pop    = pop && !empty;
  assign head_word = mem[rd_ptr];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap on their own width
      if (do_push) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + (PTR_W+1)'(1);
        2'b01:   count <= count - (PTR_W+1)'(1);
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= push_word;
    end
  end

endmodule

// ==== hw/uop_sender.sv ====
/*
 * Micro-op sender
 *   pops the queue head into output registers
 *   four-phase req/ack toward the execute side
 */
`timescale 1ns/1ps

module uop_sender (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                empty,
  input  vdec_pkg::uop_word_t head_word,
  output logic                pop,
  output logic                uop_req,
  input  logic                uop_ack,
  output vdec_pkg::elem_off_t vs2_off0,
  output vdec_pkg::elem_off_t vs2_off1,
  output vdec_pkg::elem_off_t vd_off0,
  output vdec_pkg::elem_off_t vd_off1,
  output logic                wen0,
  output logic                wen1,
  output logic                uop_last
);
  import vdec_pkg::*;

  send_state_e state;

  assign pop = (state == EMPTY) && !empty;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state   <= EMPTY;
      uop_req <= 1'b0;
    end else begin
      case (state)
        EMPTY: begin
          if (pop) begin
            uop_req <= 1'b1;
            state   <= REQ_HIGH;
          end
        end
        REQ_HIGH: begin
          if (uop_ack) begin
            uop_req <= 1'b0;
            state   <= WAIT_ACK_LOW;
          end
        end
        // next pop only once ack is seen low
        WAIT_ACK_LOW: begin
          if (!uop_ack) begin
            state <= EMPTY;
          end
        end
        default: state <= EMPTY;
      endcase
    end
  end

  // fields held while uop_req is high
  always_ff @(posedge CLK) begin
    if (pop) begin
      {vs2_off0, vs2_off1, vd_off0, vd_off1, wen0, wen1, uop_last} <= head_word;
    end
  end

endmodule

// ==== hw/vdec_cfg.svh ====
/*
 * Vector decode stage configuration
 *   offset, count and opcode widths
 *   element limit and default micro-op queue depth
 */
`ifndef VDEC_CFG_SVH
`define VDEC_CFG_SVH

// element offsets wrap modulo 2**VDEC_OFF_W
`define VDEC_OFF_W       8
`define VDEC_CNT_W       6
`define VDEC_MAX_ELEMS   32
`define VDEC_OP_W        4
`define VDEC_QUEUE_DEPTH 4

`endif

// ==== hw/vdec_pkg.sv ====
/*
 * Shared types of the vector decode stage
 *   element offset, count, mask, immediate and micro-op word
 *   opcode and offset source enums, FSM state enums
 */
`include "vdec_cfg.svh"

package vdec_pkg;

  typedef logic [`VDEC_OFF_W-1:0]     elem_off_t;
  typedef logic [`VDEC_CNT_W-1:0]     elem_cnt_t;
  typedef logic [`VDEC_MAX_ELEMS-1:0] mask_t;
  typedef logic [4:0]                 imm5_t;

  // {vs2_off0, vs2_off1, vd_off0, vd_off1, wen0, wen1, last}
  typedef logic [4*`VDEC_OFF_W+2:0]   uop_word_t;

  typedef enum logic [`VDEC_OP_W-1:0] {
    VOP_ARITH, VOP_SLIDEUP_X, VOP_SLIDEUP_I, VOP_SLIDEDOWN_X, VOP_SLIDEDOWN_I,
    VOP_SLIDE1UP, VOP_SLIDE1DOWN, VOP_GATHER_X, VOP_GATHER_I, VOP_MV_S
  } vop_e;

  typedef enum logic [2:0] {
    VS2_NORMAL, VS2_IDX_PLUS_RS1, VS2_IDX_PLUS_UIMM, VS2_IDX_PLUS_1,
    VS2_IDX_MINUS_1, VS2_RS1, VS2_UIMM, VS2_ZERO
  } vs2_src_e;

  typedef enum logic [1:0] {
    VD_NORMAL, VD_ZERO, VD_IDX_PLUS_RS1, VD_IDX_PLUS_UIMM
  } vd_src_e;

  typedef enum logic [1:0] {IDLE, ISSUE, WAIT_REQ_LOW} seq_state_e;

  typedef enum logic [1:0] {EMPTY, REQ_HIGH, WAIT_ACK_LOW} send_state_e;

endpackage

// ==== hw/vector_decode_stage.sv ====
/*
 * Vector decode stage top
 *   element sequencer, micro-op queue and sender
 *   instruction handshake in, micro-op handshake out
 */
`timescale 1ns/1ps

module vector_decode_stage (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                instr_req,
  output logic                instr_ack,
  input  vdec_pkg::vop_e      op,
  input  logic                vm,
  input  vdec_pkg::imm5_t     imm5,
  input  vdec_pkg::elem_off_t rs1_off,
  input  vdec_pkg::elem_cnt_t vl,
  input  vdec_pkg::elem_cnt_t vstart,
  input  vdec_pkg::mask_t     v0,
  output logic                uop_req,
  input  logic                uop_ack,
  output vdec_pkg::elem_off_t vs2_off0,
  output vdec_pkg::elem_off_t vs2_off1,
  output vdec_pkg::elem_off_t vd_off0,
  output vdec_pkg::elem_off_t vd_off1,
  output logic                wen0,
  output logic                wen1,
  output logic                uop_last
);
  import vdec_pkg::*;

  logic      push;
  logic      full;
  logic      pop;
  logic      empty;
  uop_word_t push_word;
  uop_word_t head_word;

  element_sequencer element_sequencer_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .instr_req (instr_req),
    .instr_ack (instr_ack),
    .op        (op),
    .vm        (vm),
    .imm5      (imm5),
    .rs1_off   (rs1_off),
    .vl        (vl),
    .vstart    (vstart),
    .v0        (v0),
    .full      (full),
    .push      (push),
    .push_word (push_word)
  );

  uop_queue uop_queue_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .push      (push),
    .push_word (push_word),
    .full      (full),
    .pop       (pop),
    .head_word (head_word),
    .empty     (empty)
  );

  uop_sender uop_sender_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .empty     (empty),
    .head_word (head_word),
    .pop       (pop),
    .uop_req   (uop_req),
    .uop_ack   (uop_ack),
    .vs2_off0  (vs2_off0),
    .vs2_off1  (vs2_off1),
    .vd_off0   (vd_off0),
    .vd_off1   (vd_off1),
    .wen0      (wen0),
    .wen1      (wen1),
    .uop_last  (uop_last)
  );

endmodule

// ==== hw/vop_decoder.sv ====
/*
 * Opcode decoder
 *   vs2 and vd offset source per opcode
 *   single-element flag for scalar moves
 */
`timescale 1ns/1ps

module vop_decoder (
  input  vdec_pkg::vop_e     op,
  output vdec_pkg::vs2_src_e vs2_src,
  output vdec_pkg::vd_src_e  vd_src,
  output logic               single_elem
);
  import vdec_pkg::*;

  always_comb begin
    // arith behaviour unless the opcode says otherwise
    vs2_src     = VS2_NORMAL;
    vd_src      = VD_NORMAL;
    single_elem = 1'b0;
    case (op)
      VOP_SLIDEUP_X:   vd_src = VD_IDX_PLUS_RS1;
      VOP_SLIDEUP_I:   vd_src = VD_IDX_PLUS_UIMM;
      VOP_SLIDEDOWN_X: vs2_src = VS2_IDX_PLUS_RS1;
      VOP_SLIDEDOWN_I: vs2_src = VS2_IDX_PLUS_UIMM;
      // slide1up reads the element below
      VOP_SLIDE1UP:    vs2_src = VS2_IDX_MINUS_1;
      VOP_SLIDE1DOWN:  vs2_src = VS2_IDX_PLUS_1;
      VOP_GATHER_X:    vs2_src = VS2_RS1;
      VOP_GATHER_I:    vs2_src = VS2_UIMM;
      VOP_MV_S: begin
        vs2_src     = VS2_ZERO;
        vd_src      = VD_ZERO;
        single_elem = 1'b1;
      end
      default: begin
        vs2_src = VS2_NORMAL;
        vd_src  = VD_NORMAL;
      end
    endcase
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the vector decode stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f tb.f \
  --top-module vdec_tb \
  -o vdec_sim

./obj_dir/vdec_sim

// ==== tb.f ====
+incdir+hw
hw/vdec_pkg.sv
hw/vop_decoder.sv
hw/element_sequencer.sv
hw/uop_queue.sv
hw/uop_sender.sv
hw/vector_decode_stage.sv
dv/tb_clock_gen.sv
dv/vdec_tb.sv
